/* Makefile */
SRCS := l1_cache_top.f $(wildcard rtl/*.sv rtl/*.svh sim/*.sv)

.PHONY: all run clean

all: run

obj_dir/Vtb_l1_cache: $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_l1_cache \
		-f l1_cache_top.f

run: obj_dir/Vtb_l1_cache
	./obj_dir/Vtb_l1_cache > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "sim failed" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log

/* l1_cache_top.f */
+incdir+rtl
rtl/cache_line_pkg.sv
rtl/cache_req_pkg.sv
rtl/trace_decode.sv
rtl/req_fifo.sv
rtl/set_lookup.sv
rtl/cache_stats.sv
rtl/l1_cache_top.sv
sim/l1_cache_asserts.sv
sim/tb_l1_cache.sv

/* rtl/cache_line_pkg.sv */
`default_nettype none

`include "cache_params.svh"

package cache_line_pkg;

	// MESI coherence state of one stored line
	// Invalid must stay zero, it is the reset value of every line
	typedef enum logic [1:0] {
		MESI_INVALID   = 2'd0,
		MESI_SHARED    = 2'd1,
		MESI_EXCLUSIVE = 2'd2,
		MESI_MODIFIED  = 2'd3
	} mesi_t;

	// Stored tag, upper address bits
	typedef logic [`TAG_BITS-1:0] tag_t;

	// True-LRU age per way
	// 0 is least recent, WAYS-1 most recent
	typedef logic [`WAY_BITS-1:0] lru_age_t;

	// Way number inside a set
	typedef logic [`WAY_BITS-1:0] way_t;

	// Age given to the way just accessed
	localparam lru_age_t AGE_MRU = lru_age_t'(`WAYS - 1);

endpackage

`default_nettype wire

/* rtl/cache_params.svh */
`ifndef CACHE_PARAMS_SVH
`define CACHE_PARAMS_SVH

// Address split for the data directory
`define ADDR_BITS   32
// Byte offset inside a 64-byte line
`define OFFSET_BITS 6
// 16 sets
`define INDEX_BITS  4
`define TAG_BITS    (`ADDR_BITS - `INDEX_BITS - `OFFSET_BITS)

// Set count follows the index width
`define SETS        (1 << `INDEX_BITS)

// 8-way set associative
`define WAYS        8
`define WAY_BITS    3

// Request buffer between decoder and lookup
`define FIFO_DEPTH  4

// Width of each statistics counter
`define STAT_BITS   32

`endif

/* rtl/cache_req_pkg.sv */
`default_nettype none

`include "cache_params.svh"

package cache_req_pkg;

	import cache_line_pkg::*;

	// Internal command encoding
	typedef enum logic [1:0] {
		CMD_READ      = 2'd0,
		CMD_WRITE     = 2'd1,
		CMD_SNOOP_INV = 2'd2,
		CMD_CLEAR     = 2'd3
	} cmd_t;

	// Trace file command codes
	localparam logic [3:0] TRACE_READ      = 4'd0;
	localparam logic [3:0] TRACE_WRITE     = 4'd1;
	localparam logic [3:0] TRACE_SNOOP_INV = 4'd3;
	localparam logic [3:0] TRACE_CLEAR     = 4'd8;

	typedef logic [`INDEX_BITS-1:0] set_idx_t;

	// Decoded request, byte offset already dropped
	typedef struct packed {
		cmd_t     cmd;
		tag_t     tag;
		set_idx_t index;
	} cache_req_t;

	// One response per processed request
	typedef struct packed {
		cmd_t  cmd;
		logic  hit;
		way_t  way;
		mesi_t state;
		logic  writeback;
	} cache_rsp_t;

	typedef logic [`STAT_BITS-1:0] stat_cnt_t;

	// Running access counters
	typedef struct packed {
		stat_cnt_t reads;
		stat_cnt_t writes;
		stat_cnt_t hits;
		stat_cnt_t misses;
	} cache_stats_t;

endpackage

`default_nettype wire

/* rtl/cache_stats.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_stats
	import cache_req_pkg::*;
(
	input  wire logic       i_clk,
	input  wire logic       i_arst_n,
	input  wire logic       i_rsp_valid,
	input  wire cache_rsp_t i_rsp,
	output cache_stats_t    o_stats
);

	logic is_access;

	// Holds at all ones instead of wrapping
	function automatic stat_cnt_t sat_inc(input stat_cnt_t cnt);
		return (cnt == '1) ? cnt : cnt + 1'b1;
	endfunction

	// Snoops count neither as access nor as hit or miss
	assign is_access = (i_rsp.cmd == CMD_READ) || (i_rsp.cmd == CMD_WRITE);

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_stats <= '0;
		end else if (i_rsp_valid) begin
			if (i_rsp.cmd == CMD_CLEAR) begin
				o_stats <= '0;
			end else begin
				if (i_rsp.cmd == CMD_READ)
					o_stats.reads <= sat_inc(o_stats.reads);
				if (i_rsp.cmd == CMD_WRITE)
					o_stats.writes <= sat_inc(o_stats.writes);
				// Hit or miss per access
				if (is_access && i_rsp.hit)
					o_stats.hits <= sat_inc(o_stats.hits);
				if (is_access && !i_rsp.hit)
					o_stats.misses <= sat_inc(o_stats.misses);
			end
		end
	end

endmodule

`default_nettype wire

/* rtl/l1_cache_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cache_params.svh"

module l1_cache_top
	import cache_req_pkg::*;
(
	input  wire logic                  i_clk,
	input  wire logic                  i_arst_n,
	input  wire logic                  i_cmd_valid,
	input  wire logic [3:0]            i_cmd_code,
	input  wire logic [`ADDR_BITS-1:0] i_addr,
	output logic                       o_rsp_valid,
	output cache_rsp_t                 o_rsp,
	output cache_stats_t               o_stats,
	output logic                       o_bad_cmd,
	output logic                       o_overflow
);

	// Decoder to buffer
	logic       dec_req_valid;
	cache_req_t dec_req;

	// Buffer head to lookup
	logic       fifo_not_empty;
	cache_req_t fifo_head;
	logic       lookup_pop;

	trace_decode u_decode (
		.i_clk       (i_clk),
		.i_arst_n    (i_arst_n),
		.i_cmd_valid (i_cmd_valid),
		.i_cmd_code  (i_cmd_code),
		.i_addr      (i_addr),
		.o_req_valid (dec_req_valid),
		.o_req       (dec_req),
		.o_bad_cmd   (o_bad_cmd)
	);

	// Absorbs bursts while a lookup is busy
	req_fifo #(
		.payload_t (cache_req_t),
		.DEPTH     (`FIFO_DEPTH)
	) u_fifo (
		.i_clk       (i_clk),
		.i_arst_n    (i_arst_n),
		.i_push      (dec_req_valid),
		.i_data      (dec_req),
		.i_pop       (lookup_pop),
		.o_data      (fifo_head),
		.o_not_empty (fifo_not_empty),
		.o_overflow  (o_overflow)
	);

	set_lookup u_lookup (
		.i_clk       (i_clk),
		.i_arst_n    (i_arst_n),
		.i_req_valid (fifo_not_empty),
		.i_req       (fifo_head),
		.o_pop       (lookup_pop),
		.o_rsp_valid (o_rsp_valid),
		.o_rsp       (o_rsp)
	);

	// Counters watch the same response stream
	cache_stats u_stats (
		.i_clk       (i_clk),
		.i_arst_n    (i_arst_n),
		.i_rsp_valid (o_rsp_valid),
		.i_rsp       (o_rsp),
		.o_stats     (o_stats)
	);

endmodule

`default_nettype wire

/* rtl/req_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cache_params.svh"

module req_fifo #(
	parameter type payload_t = logic [7:0],
	parameter int  DEPTH     = `FIFO_DEPTH
) (
	input  wire logic     i_clk,
	input  wire logic     i_arst_n,
	input  wire logic     i_push,
	input  wire payload_t i_data,
	input  wire logic     i_pop,
	output payload_t      o_data,
	output logic          o_not_empty,
	output logic          o_overflow
);

	localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_BITS = $clog2(DEPTH + 1);

	// Storage, no reset needed
	payload_t            mem [DEPTH];
	logic [PTR_BITS-1:0] wr_ptr;
	logic [PTR_BITS-1:0] rd_ptr;
	logic [CNT_BITS-1:0] count;
	logic                full;
	logic                do_push;
	logic                do_pop;

	// Wrap at DEPTH, works for any depth
	function automatic logic [PTR_BITS-1:0] ptr_next(input logic [PTR_BITS-1:0] ptr);
		if (ptr == PTR_BITS'(DEPTH - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	assign full    = (count == CNT_BITS'(DEPTH));
	assign do_pop  = i_pop && (count != '0);
	// A pop in the same cycle frees a slot for the push
	assign do_push = i_push && (!full || do_pop);

	// Head is visible while not empty
	assign o_data      = mem[rd_ptr];
	assign o_not_empty = (count != '0);

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			count      <= '0;
			o_overflow <= 1'b0;
		end else begin
			if (do_push)
				wr_ptr <= ptr_next(wr_ptr);
			if (do_pop)
				rd_ptr <= ptr_next(rd_ptr);
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
			// Dropped push, sticky until reset
			if (i_push && !do_push)
				o_overflow <= 1'b1;
		end
	end

	always_ff @(posedge i_clk) begin
		if (do_push)
			mem[wr_ptr] <= i_data;
	end

endmodule

`default_nettype wire

/* rtl/set_lookup.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cache_params.svh"

module set_lookup
	import cache_line_pkg::*;
	import cache_req_pkg::*;
(
	input  wire logic       i_clk,
	input  wire logic       i_arst_n,
	input  wire logic       i_req_valid,
	input  wire cache_req_t i_req,
	output logic            o_pop,
	output logic            o_rsp_valid,
	output cache_rsp_t      o_rsp
);

	// Line arrays, 16 sets by 8 ways
	tag_t     tag_arr  [`SETS][`WAYS];
	mesi_t    mesi_arr [`SETS][`WAYS];
	lru_age_t age_arr  [`SETS][`WAYS];

	// Captured in the read phase
	logic       busy_q;
	cache_req_t req_q;
	logic       hit_q;
	way_t       way_q;
	mesi_t      old_state_q;

	// Read phase lookup on the FIFO head
	logic [`WAYS-1:0] hit_vec;
	logic             rd_hit;
	way_t             rd_hit_way;
	logic             rd_has_inv;
	way_t             rd_inv_way;
	way_t             rd_lru_way;
	way_t             rd_way;

	// Write phase
	logic     is_access;
	mesi_t    new_state;
	logic     writeback;
	lru_age_t acc_age;

	// One request in flight, pop again two cycles later at the earliest
	assign o_pop = i_req_valid && !busy_q;

	always_comb begin
		hit_vec    = '0;
		rd_has_inv = 1'b0;
		rd_hit_way = '0;
		rd_inv_way = '0;
		rd_lru_way = '0;
		// Downward scan so the lowest matching way wins
		for (int w = `WAYS - 1; w >= 0; w--) begin
			hit_vec[w] = (mesi_arr[i_req.index][w] != MESI_INVALID) &&
				(tag_arr[i_req.index][w] == i_req.tag);
			if (hit_vec[w])
				rd_hit_way = way_t'(w);
			if (mesi_arr[i_req.index][w] == MESI_INVALID) begin
				rd_has_inv = 1'b1;
				rd_inv_way = way_t'(w);
			end
			if (age_arr[i_req.index][w] == '0)
				rd_lru_way = way_t'(w);
		end
		rd_hit = |hit_vec;
		// Hit way, else first free way, else the oldest
		if (rd_hit)
			rd_way = rd_hit_way;
		else if (rd_has_inv)
			rd_way = rd_inv_way;
		else
			rd_way = rd_lru_way;
	end

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n)
			busy_q <= 1'b0;
		else
			busy_q <= o_pop;
	end

	always_ff @(posedge i_clk) begin
		if (o_pop) begin
			req_q       <= i_req;
			hit_q       <= rd_hit;
			way_q       <= rd_way;
			// State of the hit line or of the victim
			old_state_q <= mesi_arr[i_req.index][rd_way];
		end
	end

	assign is_access = (req_q.cmd == CMD_READ) || (req_q.cmd == CMD_WRITE);
	assign acc_age   = age_arr[req_q.index][way_q];
	// Dirty victim leaves on a read or write miss
	assign writeback = is_access && !hit_q && (old_state_q == MESI_MODIFIED);

	// Next MESI state of the selected way
	always_comb begin
		case (req_q.cmd)
			CMD_READ:  new_state = hit_q ? old_state_q : MESI_EXCLUSIVE;
			CMD_WRITE: new_state = MESI_MODIFIED;
			// Snoop and clear both leave the line Invalid
			default:   new_state = MESI_INVALID;
		endcase
	end

	// Response during the write phase
	assign o_rsp_valid = busy_q;

	always_comb begin
		o_rsp.cmd       = req_q.cmd;
		o_rsp.hit       = hit_q && (req_q.cmd != CMD_CLEAR);
		o_rsp.way       = (req_q.cmd == CMD_CLEAR) ? way_t'(0) : way_q;
		o_rsp.state     = new_state;
		o_rsp.writeback = writeback;
	end

	// MESI and age arrays
	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			for (int s = 0; s < `SETS; s++) begin
				for (int w = 0; w < `WAYS; w++) begin
					mesi_arr[s][w] <= MESI_INVALID;
					age_arr[s][w]  <= lru_age_t'(w);
				end
			end
		end else if (busy_q) begin
			case (req_q.cmd)
				CMD_READ, CMD_WRITE: begin
					mesi_arr[req_q.index][way_q] <= new_state;
					// Younger ways than the accessed one each age by one
					for (int w = 0; w < `WAYS; w++) begin
						if (age_arr[req_q.index][w] > acc_age)
							age_arr[req_q.index][w] <= age_arr[req_q.index][w] - 1'b1;
					end
					age_arr[req_q.index][way_q] <= AGE_MRU;
				end
				CMD_SNOOP_INV: begin
					// Miss leaves the set untouched
					if (hit_q)
						mesi_arr[req_q.index][way_q] <= MESI_INVALID;
				end
				default: begin
					// Clear, back to the reset picture
					for (int s = 0; s < `SETS; s++) begin
						for (int w = 0; w < `WAYS; w++) begin
							mesi_arr[s][w] <= MESI_INVALID;
							age_arr[s][w]  <= lru_age_t'(w);
						end
					end
				end
			endcase
		end
	end

	// Tag only changes on a fill
	always_ff @(posedge i_clk) begin
		if (busy_q && is_access && !hit_q)
			tag_arr[req_q.index][way_q] <= req_q.tag;
	end

endmodule

`default_nettype wire

/* rtl/trace_decode.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cache_params.svh"

module trace_decode
	import cache_req_pkg::*;
(
	input  wire logic                  i_clk,
	input  wire logic                  i_arst_n,
	input  wire logic                  i_cmd_valid,
	input  wire logic [3:0]            i_cmd_code,
	input  wire logic [`ADDR_BITS-1:0] i_addr,
	output logic                       o_req_valid,
	output cache_req_t                 o_req,
	output logic                       o_bad_cmd
);

	cmd_t dec_cmd;
	logic dec_known;

	// Trace code to internal command
	always_comb begin
		dec_known = 1'b1;
		dec_cmd   = CMD_READ;
		case (i_cmd_code)
			TRACE_READ:      dec_cmd = CMD_READ;
			TRACE_WRITE:     dec_cmd = CMD_WRITE;
			TRACE_SNOOP_INV: dec_cmd = CMD_SNOOP_INV;
			TRACE_CLEAR:     dec_cmd = CMD_CLEAR;
			// Anything else is flagged, no request
			default:         dec_known = 1'b0;
		endcase
	end

	// Strobes, one cycle after the input strobe
	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_req_valid <= 1'b0;
			o_bad_cmd   <= 1'b0;
		end else begin
			o_req_valid <= i_cmd_valid && dec_known;
			o_bad_cmd   <= i_cmd_valid && !dec_known;
		end
	end

	// Request payload
	// Tag from the top bits, index just above the byte offset
	always_ff @(posedge i_clk) begin
		if (i_cmd_valid) begin
			o_req.cmd   <= dec_cmd;
			o_req.tag   <= i_addr[`ADDR_BITS-1 -: `TAG_BITS];
			o_req.index <= i_addr[`OFFSET_BITS +: `INDEX_BITS];
		end
	end

endmodule

`default_nettype wire

/* sim/l1_cache_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module l1_cache_asserts
	import cache_line_pkg::*;
	import cache_req_pkg::*;
(
	input wire logic       i_clk,
	input wire logic       i_arst_n,
	input wire logic       i_pop,
	input wire logic       i_rsp_valid,
	input wire cache_rsp_t i_rsp
);

	// One request in flight, so never two pops in a row
	a_pop_spacing: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		i_pop |=> !i_pop)
		else $error("pop on two consecutive cycles");

	// Write phase right after the read phase
	a_rsp_after_pop: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		i_pop |=> i_rsp_valid)
		else $error("no response one cycle after a pop");

	// Only a snoop may hit and leave the line Invalid
	a_hit_state: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		(i_rsp_valid && i_rsp.hit && i_rsp.cmd != CMD_SNOOP_INV) |->
		(i_rsp.state != MESI_INVALID))
		else $error("hit response reports an Invalid line");

endmodule

bind set_lookup l1_cache_asserts u_asserts (
	.i_clk       (i_clk),
	.i_arst_n    (i_arst_n),
	.i_pop       (o_pop),
	.i_rsp_valid (o_rsp_valid),
	.i_rsp       (o_rsp)
);

`default_nettype wire

/* sim/tb_l1_cache.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cache_params.svh"

module tb_l1_cache
	import cache_line_pkg::*;
	import cache_req_pkg::*;
();

	localparam int N_RANDOM = 400;
	// Evict 10, snoop 4, clear 2, bad code 1
	localparam int N_DIRECT = 17;
	localparam int TIMEOUT  = 6 * (N_RANDOM + N_DIRECT) + 100;

	// Trace codes
	localparam logic [3:0] CODE_READ  = 4'd0;
	localparam logic [3:0] CODE_WRITE = 4'd1;
	localparam logic [3:0] CODE_SNOOP = 4'd3;
	localparam logic [3:0] CODE_CLEAR = 4'd8;
	localparam logic [3:0] CODE_BAD   = 4'd5;

	typedef logic [`OFFSET_BITS-1:0] offset_t;

	logic                  clk;
	logic                  arst_n;
	logic                  cmd_valid;
	logic [3:0]            cmd_code;
	logic [`ADDR_BITS-1:0] addr;
	logic                  rsp_valid;
	cache_rsp_t            rsp;
	cache_stats_t          stats;
	logic                  bad_cmd;
	logic                  overflow;

	// Reference model of the directory
	tag_t         m_tag  [`SETS][`WAYS];
	mesi_t        m_mesi [`SETS][`WAYS];
	lru_age_t     m_age  [`SETS][`WAYS];
	cache_stats_t m_stats;
	cache_rsp_t   exp_rsp_q   [$];
	cache_stats_t exp_stats_q [$];

	// Monitor state
	cache_stats_t pend_stats;
	logic         stats_pending = 1'b0;
	cache_rsp_t   last_rsp;
	int           bad_expected  = 0;
	int           bad_seen      = 0;
	int           cycles        = 0;
	integer       seed;
	string        test_name     = "reset";

	l1_cache_top u_dut (
		.i_clk       (clk),
		.i_arst_n    (arst_n),
		.i_cmd_valid (cmd_valid),
		.i_cmd_code  (cmd_code),
		.i_addr      (addr),
		.o_rsp_valid (rsp_valid),
		.o_rsp       (rsp),
		.o_stats     (stats),
		.o_bad_cmd   (bad_cmd),
		.o_overflow  (overflow)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("sim failed");
		$fatal(1, "run stopped");
	endtask

	task automatic compare_rsp(input cache_rsp_t exp, input cache_rsp_t act);
		if (exp !== act)
			abort_run($sformatf("mismatch %s rsp expected %h actual %h", test_name, exp, act));
	endtask

	task automatic compare_stats(input cache_stats_t exp, input cache_stats_t act);
		if (exp !== act)
			abort_run($sformatf("mismatch %s stats expected %h actual %h",
				test_name, exp, act));
	endtask

	function automatic cache_rsp_t make_rsp(input cmd_t cmd, input logic hit, input way_t way,
		input mesi_t state, input logic wb);
		cache_rsp_t r;
		r.cmd       = cmd;
		r.hit       = hit;
		r.way       = way;
		r.state     = state;
		r.writeback = wb;
		return r;
	endfunction

	// All lines Invalid and ages in way order
	task automatic model_reset();
		for (int s = 0; s < `SETS; s++) begin
			for (int w = 0; w < `WAYS; w++) begin
				m_tag[s][w]  = '0;
				m_mesi[s][w] = MESI_INVALID;
				m_age[s][w]  = lru_age_t'(w);
			end
		end
	endtask

	// Applies one command and queues the expected response and counters
	task automatic model_step(input cmd_t cmd, input tag_t tag, input set_idx_t idx);
		cache_rsp_t r;
		logic       hit;
		logic       found;
		way_t       way;
		lru_age_t   acc;
		hit   = 1'b0;
		found = 1'b0;
		way   = '0;
		for (int w = 0; w < `WAYS; w++) begin
			if (!hit && m_mesi[idx][w] != MESI_INVALID && m_tag[idx][w] == tag) begin
				hit = 1'b1;
				way = way_t'(w);
			end
		end
		// Victim is the first free way, else the oldest
		if (!hit) begin
			for (int w = 0; w < `WAYS; w++) begin
				if (!found && m_mesi[idx][w] == MESI_INVALID) begin
					found = 1'b1;
					way   = way_t'(w);
				end
			end
			if (!found) begin
				for (int w = 0; w < `WAYS; w++) begin
					if (m_age[idx][w] == '0)
						way = way_t'(w);
				end
			end
		end
		r = make_rsp(cmd, hit, way, MESI_INVALID, 1'b0);
		case (cmd)
			CMD_READ, CMD_WRITE: begin
				r.writeback = !hit && (m_mesi[idx][way] == MESI_MODIFIED);
				if (cmd == CMD_WRITE)
					r.state = MESI_MODIFIED;
				else if (hit)
					r.state = m_mesi[idx][way];
				else
					r.state = MESI_EXCLUSIVE;
				m_mesi[idx][way] = r.state;
				m_tag[idx][way]  = tag;
				// Younger ways step down one age
				acc = m_age[idx][way];
				for (int w = 0; w < `WAYS; w++) begin
					if (m_age[idx][w] > acc)
						m_age[idx][w] = m_age[idx][w] - 1'b1;
				end
				m_age[idx][way] = lru_age_t'(`WAYS - 1);
				if (cmd == CMD_READ)
					m_stats.reads = m_stats.reads + 1'b1;
				else
					m_stats.writes = m_stats.writes + 1'b1;
				if (hit)
					m_stats.hits = m_stats.hits + 1'b1;
				else
					m_stats.misses = m_stats.misses + 1'b1;
			end
			CMD_SNOOP_INV: begin
				if (hit)
					m_mesi[idx][way] = MESI_INVALID;
			end
			default: begin
				// Clear reports no hit and way 0
				r.hit = 1'b0;
				r.way = '0;
				model_reset();
				m_stats = '0;
			end
		endcase
		exp_rsp_q.push_back(r);
		exp_stats_q.push_back(m_stats);
	endtask

	// One strobe and one idle cycle
	task automatic send_cmd(input logic [3:0] code, input tag_t tag, input set_idx_t idx);
		offset_t offset;
		offset = offset_t'($random(seed));
		@(posedge clk);
		cmd_valid <= 1'b1;
		cmd_code  <= code;
		addr      <= {tag, idx, offset};
		case (code)
			CODE_READ:  model_step(CMD_READ, tag, idx);
			CODE_WRITE: model_step(CMD_WRITE, tag, idx);
			CODE_SNOOP: model_step(CMD_SNOOP_INV, tag, idx);
			CODE_CLEAR: model_step(CMD_CLEAR, tag, idx);
			default:    bad_expected++;
		endcase
		@(posedge clk);
		cmd_valid <= 1'b0;
	endtask

	// Until every expected response and strobe is seen
	task automatic wait_drain();
		while (exp_rsp_q.size() != 0 || stats_pending || bad_seen != bad_expected)
			@(posedge clk);
		@(negedge clk);
	endtask

	// Response and counter monitor on the falling edge
	always @(negedge clk) begin
		if (arst_n) begin
			if (overflow)
				abort_run("request FIFO overflow flag went high");
			if (bad_cmd) begin
				bad_seen++;
				if (bad_seen > bad_expected)
					abort_run("bad command strobe for a valid trace code");
			end
			// Counters lag the response by one cycle
			if (stats_pending) begin
				compare_stats(pend_stats, stats);
				stats_pending = 1'b0;
			end
			if (rsp_valid) begin
				if (exp_rsp_q.size() == 0)
					abort_run("response with no command outstanding");
				compare_rsp(exp_rsp_q.pop_front(), rsp);
				last_rsp      = rsp;
				pend_stats    = exp_stats_q.pop_front();
				stats_pending = 1'b1;
			end
		end
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= TIMEOUT)
			abort_run($sformatf("timeout after %0d cycles with responses still missing", cycles));
	end

	initial begin
		logic [3:0] code;
		tag_t       tag;
		set_idx_t   idx;
		int         gap;
		cmd_valid = 1'b0;
		cmd_code  = '0;
		addr      = '0;
		arst_n    = 1'b0;
		seed      = 19;
		m_stats   = '0;
		model_reset();
		repeat (4) @(posedge clk);
		arst_n <= 1'b1;

		// 12 tags over 4 sets give hits and evictions
		test_name = "random";
		for (int i = 0; i < N_RANDOM; i++) begin
			tag  = tag_t'(32'h100 + ($unsigned($random(seed)) % 12));
			idx  = set_idx_t'($unsigned($random(seed)) % 4);
			code = ($unsigned($random(seed)) % 3 == 0) ? CODE_WRITE : CODE_READ;
			send_cmd(code, tag, idx);
			gap = $unsigned($random(seed)) % 3;
			repeat (gap) @(posedge clk);
		end
		wait_drain();

		// Dirty way 0 ages out on the ninth tag
		test_name = "evict";
		send_cmd(CODE_CLEAR, '0, '0);
		send_cmd(CODE_WRITE, tag_t'(32'h200), set_idx_t'(5));
		for (int t = 1; t < 9; t++)
			send_cmd(CODE_READ, tag_t'(32'h200 + t), set_idx_t'(5));
		wait_drain();
		compare_rsp(make_rsp(CMD_READ, 1'b0, way_t'(0), MESI_EXCLUSIVE, 1'b1), last_rsp);

		test_name = "snoop";
		send_cmd(CODE_READ, tag_t'(32'h300), set_idx_t'(6));
		send_cmd(CODE_READ, tag_t'(32'h301), set_idx_t'(6));
		send_cmd(CODE_SNOOP, tag_t'(32'h300), set_idx_t'(6));
		wait_drain();
		compare_rsp(make_rsp(CMD_SNOOP_INV, 1'b1, way_t'(0), MESI_INVALID, 1'b0), last_rsp);
		// Freed way is the lowest Invalid one
		send_cmd(CODE_READ, tag_t'(32'h300), set_idx_t'(6));
		wait_drain();
		compare_rsp(make_rsp(CMD_READ, 1'b0, way_t'(0), MESI_EXCLUSIVE, 1'b0), last_rsp);

		test_name = "clear";
		send_cmd(CODE_CLEAR, '0, '0);
		wait_drain();
		compare_stats('0, stats);
		send_cmd(CODE_READ, tag_t'(32'h201), set_idx_t'(5));
		wait_drain();
		compare_rsp(make_rsp(CMD_READ, 1'b0, way_t'(0), MESI_EXCLUSIVE, 1'b0), last_rsp);

		// Unknown code gives a strobe only
		test_name = "bad_cmd";
		send_cmd(CODE_BAD, tag_t'(32'h201), set_idx_t'(5));
		wait_drain();
		repeat (8) @(posedge clk);

		$display("sim passed");
		$finish;
	end

endmodule

`default_nettype wire
